/* sim.f */
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/opcodeDecoder.sv
hdl/stepSequencer.sv
hdl/strobeGenerator.sv
hdl/mainControl.sv
tests/mainControlTb.sv

/* Makefile */
# Verilator flow for the main control unit testbench
# override on the command line, e.g. make sim MEM_WAIT=3

VERILATOR ?= verilator
TOP       ?= mainControlTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
MEM_WAIT  ?= 2
VFLAGS    ?= --assert --timing

COMMON = $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GmemWaitCycles=$(MEM_WAIT)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON)

# the binary exits non-zero on $$fatal, so make fails with the test
sim:
	$(VERILATOR) --binary $(COMMON) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/mainControlTb.sv */
module mainControlTb #(
    parameter int memWaitCycles = 2
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriod      = 10;
    localparam int driveDelay     = 1;
    localparam int resetCycles    = 10;
    localparam int numInstr       = 200;
    localparam int watchdogCycles = numInstr * 20 + resetCycles;

    // seventeen listed opcodes then four words that decode to nothing
    localparam logic [5:0] opcodeList [21] = '{
        opAlu, opAddi, opSubi, opSlai, opSrai, opSrli,
        opLd, opSt, opLdsp, opStsp, opMove,
        opBr, opBmi, opBpl, opBz, opHalt, opNop,
        6'b000100, 6'b101001, 6'b101010, 6'b111111
    };

    logic      clk;
    logic      reset;
    opcodeWord opcode;
    logic      interrupt;
    ctrlFields fields;
    memStrobes strobes;
    logic      busy;

    // reference state of the instruction in flight
    instrClass expKind;
    ctrlFields expFields;
    ctrlFields heldFields; // fields of the previous instruction
    int        stepIndex; // cycles since busy rose
    int        seed = 25;

    mainControl #(
        .memWaitCycles (memWaitCycles)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .interrupt (interrupt),
        .fields    (fields),
        .strobes   (strobes),
        .busy      (busy)
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        if (reset || !busy)
            stepIndex <= 0;
        else
            stepIndex <= stepIndex + 1;
    end

    // sequence class by opcode
    function automatic instrClass classOf(input logic [5:0] op);
        case (op)
            opAlu: return aluClass;
            opAddi, opSubi, opSlai, opSrai, opSrli, opMove: return immClass;
            opLd, opLdsp: return loadClass;
            opSt, opStsp: return storeClass;
            opBr, opBmi, opBpl, opBz: return branchClass;
            opHalt: return haltClass;
            default: return nopClass;
        endcase
    endfunction

    function automatic ctrlFields fieldTable(input logic [5:0] op);
        ctrlFields f;
        f = '0;
        case (op)
            opAlu:          f.aluSource = 1'b1; // register ALU op keeps aluOp 000
            opAddi, opMove: f.aluOp = 3'b010;
            opSubi:         f.aluOp = 3'b011;
            opSlai:         f.aluOp = 3'b100;
            opSrai:         f.aluOp = 3'b101;
            opSrli:         f.aluOp = 3'b110;
            opBr:           f.branch = 3'b001;
            opBmi:          f.branch = 3'b011;
            opBpl:          f.branch = 3'b101;
            opBz:           f.branch = 3'b111;
            default:        f = '0;
        endcase
        return f;
    endfunction

    // busy length of every class but HALT
    function automatic int busyLength(input instrClass kind);
        case (kind)
            loadClass, storeClass: return 3 + memWaitCycles;
            nopClass: return 2;
            default: return 3;
        endcase
    endfunction

    // strobes expected in a given busy cycle
    function automatic memStrobes strobeSchedule(input instrClass kind, input int step);
        memStrobes s;
        s = '0;
        case (kind)
            aluClass, immClass: s.writeReg = (step == 2);
            loadClass: begin
                s.memRead  = (step >= 2);
                s.writeReg = (step == 2 + memWaitCycles); // write-back cycle
                s.memRegPC = (step == 2 + memWaitCycles);
            end
            storeClass: s.memWrite = (step >= 2);
            default: s = '0;
        endcase
        return s;
    endfunction

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("CHECK FAILED %s: expected %0h, actual %0h", testName, expected, actual);
        $display("Simulation failed");
        $fatal(1, "%s mismatch", testName);
    endtask

    // entered in the idle cycle just after the edge
    task automatic runInstruction(input logic [5:0] op);
        int len;
        int wantLen;
        int irqStep;
        opcode.raw = op;
        expKind    = classOf(op);
        heldFields = expFields;
        expFields  = fieldTable(op);
        irqStep    = 1 + ($unsigned($random(seed)) % 8);
        wantLen    = (expKind == haltClass) ? irqStep + 1 : busyLength(expKind);
        @(posedge clk);
        #driveDelay;
        assert (busy) else reportMismatch("busy start", 32'd1, 32'(busy));
        len = 0;
        while (busy) begin
            interrupt = (expKind == haltClass) && (len == irqStep); // one-cycle pulse
            @(posedge clk);
            #driveDelay;
            len++;
        end
        interrupt = 1'b0;
        assert (len == wantLen)
        else reportMismatch($sformatf("busy length %s", expKind.name()), 32'(wantLen), 32'(len));
    endtask

    idleStrobes: assert property (@(posedge clk) disable iff (reset)
        !busy |-> strobes == '0)
    else reportMismatch("idle strobes", 32'd0, 32'($sampled(strobes)));

    strobeOrder: assert property (@(posedge clk) disable iff (reset)
        busy |-> strobes == strobeSchedule(expKind, stepIndex))
    else reportMismatch($sformatf("strobe schedule step %0d", $sampled(stepIndex)),
                        32'(strobeSchedule($sampled(expKind), $sampled(stepIndex))),
                        32'($sampled(strobes)));

    // fields follow the table from the latch onward
    fieldMatch: assert property (@(posedge clk) disable iff (reset)
        (busy && stepIndex >= 1) |-> fields == expFields)
    else reportMismatch("fields", 32'($sampled(expFields)), 32'($sampled(fields)));

    // previous instruction's fields stay up to the latch
    fieldHold: assert property (@(posedge clk) disable iff (reset)
        (!busy || stepIndex == 0) |-> fields == heldFields)
    else reportMismatch("field hold", 32'($sampled(heldFields)), 32'($sampled(fields)));

    idleGap: assert property (@(posedge clk) disable iff (reset)
        $past(!busy && !reset) |-> busy)
    else reportMismatch("idle gap busy", 32'd1, 32'($sampled(busy)));

    haltHold: assert property (@(posedge clk) disable iff (reset)
        $past(busy && expKind == haltClass && stepIndex >= 1 && !interrupt) |-> busy)
    else reportMismatch("halt hold busy", 32'd1, 32'($sampled(busy)));

    haltRelease: assert property (@(posedge clk) disable iff (reset)
        $past(busy && expKind == haltClass && stepIndex >= 1 && interrupt) |-> !busy)
    else reportMismatch("halt release busy", 32'd0, 32'($sampled(busy)));

    initial begin
        int pick;
        clk        = 1'b0;
        reset      = 1'b1;
        opcode.raw = opNop;
        interrupt  = 1'b0;
        expKind    = nopClass;
        expFields  = '0;
        heldFields = '0;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        reset = 1'b0;
        // outputs still show their reset values here
        assert (!busy) else reportMismatch("reset busy", 32'd0, 32'(busy));
        assert (strobes == '0) else reportMismatch("reset strobes", 32'd0, 32'(strobes));
        assert (fields == '0) else reportMismatch("reset fields", 32'd0, 32'(fields));
        for (int i = 0; i < numInstr; i++) begin
            pick = int'($unsigned($random(seed)) % 21);
            runInstruction(opcodeList[pick]);
        end
        $display("Simulation passed");
        $finish;
    end

    // longest instruction is well under 20 cycles
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the instruction stream did not complete in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* hdl/mainControl.sv */
module mainControl #(
    parameter int memWaitCycles = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  isaPkg::opcodeWord  opcode,
    input  logic               interrupt,
    output ctrlPkg::ctrlFields fields,
    output ctrlPkg::memStrobes strobes,
    output logic               busy
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass instr;
    ctrlFields decodedFields; // unregistered table output
    stepEvents events;

    opcodeDecoder decoder (
        .opcode (opcode),
        .instr  (instr),
        .fields (decodedFields)
    );

    stepSequencer #(
        .memWaitCycles (memWaitCycles)
    ) sequencer (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .interrupt (interrupt),
        .busy      (busy),
        .events    (events)
    );

    strobeGenerator strobeGen (
        .clk      (clk),
        .reset    (reset),
        .events   (events),
        .fieldsIn (decodedFields),
        .fields   (fields),
        .strobes  (strobes)
    );

endmodule

/* hdl/strobeGenerator.sv */
module strobeGenerator (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::stepEvents events,
    input  ctrlPkg::ctrlFields fieldsIn,
    output ctrlPkg::ctrlFields fields,
    output ctrlPkg::memStrobes strobes
);

    // fields hold until the next instruction latches its own
    always_ff @(posedge clk) begin
        if (reset) begin
            fields <= '0;
        end else if (events.latchFields) begin
            fields <= fieldsIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            strobes <= '0;
        end else if (events.clearStrobes) begin
            strobes <= '0; // end of instruction
        end else begin
            if (events.regWriteOn)
                strobes.writeReg <= 1'b1;
            if (events.memReadOn)
                strobes.memRead <= 1'b1;
            if (events.memWriteOn)
                strobes.memWrite <= 1'b1;
            // load write-back, register takes memory data
            if (events.loadWriteOn) begin
                strobes.writeReg <= 1'b1;
                strobes.memRegPC <= 1'b1;
            end
        end
    end

endmodule

/* hdl/stepSequencer.sv */
module stepSequencer #(
    parameter int memWaitCycles = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  isaPkg::instrClass  instr,
    input  logic               interrupt,
    output logic               busy,
    output ctrlPkg::stepEvents events
);
    import isaPkg::*;

    // wait step lasts memWaitCycles cycles, at least one
    localparam int waitWidth = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;
    localparam logic [waitWidth-1:0] lastWait = waitWidth'(memWaitCycles - 1);

    typedef enum logic {
        idle,
        execute
    } seqState;

    seqState              state;
    logic [1:0]           step;
    logic [waitWidth-1:0] waitCount;
    logic                 waitDone;
    logic                 finalStep;
    logic                 holdStep; // stay on the current step
    logic                 memClass;

    assign busy     = (state == execute);
    assign waitDone = (waitCount == lastWait);
    assign memClass = (instr == loadClass) || (instr == storeClass);

    // step schedule per class
    //   step 0  latch fields, all classes
    //   step 1  issue the main strobe, or hold in HALT
    //   step 2  memory wait, or last step of ALU/imm/branch
    //   step 3  last step of loads and stores
    always_comb begin
        events    = '0;
        finalStep = 1'b0;
        holdStep  = 1'b0;
        if (state == execute) begin
            case (step)
                2'd0: events.latchFields = 1'b1;
                2'd1: begin
                    case (instr)
                        aluClass, immClass: events.regWriteOn = 1'b1;
                        loadClass:  events.memReadOn = 1'b1;
                        storeClass: events.memWriteOn = 1'b1;
                        haltClass: begin
                            holdStep  = !interrupt; // wait for interrupt
                            finalStep = interrupt;
                        end
                        nopClass:    finalStep = 1'b1;
                        branchClass: finalStep = 1'b0; // condition settles in the datapath
                        default:     finalStep = 1'b1;
                    endcase
                end
                2'd2: begin
                    if (memClass) begin
                        holdStep = !waitDone;
                        // write-back lands memWaitCycles after memRead
                        events.loadWriteOn = waitDone && (instr == loadClass);
                    end else begin
                        finalStep = 1'b1;
                    end
                end
                default: finalStep = 1'b1;
            endcase
            events.clearStrobes = finalStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            step      <= 2'd0;
            waitCount <= '0;
        end else if (state == idle) begin
            state <= execute; // one idle cycle between instructions
            step  <= 2'd0;
        end else if (finalStep) begin
            state     <= idle;
            step      <= 2'd0;
            waitCount <= '0;
        end else if (holdStep) begin
            if (step == 2'd2)
                waitCount <= waitCount + 1'b1;
        end else begin
            step      <= step + 2'd1;
            waitCount <= '0;
        end
    end

endmodule

/* hdl/opcodeDecoder.sv */
module opcodeDecoder (
    input  isaPkg::opcodeWord  opcode,
    output isaPkg::instrClass  instr,
    output ctrlPkg::ctrlFields fields
);
    import isaPkg::*;
    import ctrlPkg::*;

    // sequence class from group and function
    always_comb begin
        instr = nopClass;
        case (opcode.split.group)
            groupAlu: begin
                if (opcode.split.func == 4'd0)
                    instr = aluClass;
            end
            groupImm: begin
                case (opcode.split.func)
                    4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd9: instr = immClass; // incl. MOVE
                    4'd5, 4'd7: instr = loadClass;  // LD, LDSP
                    4'd6, 4'd8: instr = storeClass; // ST, STSP
                    default: instr = nopClass;
                endcase
            end
            groupSys: begin
                case (opcode.split.func)
                    4'd0, 4'd1, 4'd2, 4'd3: instr = branchClass;
                    4'd8: instr = haltClass;
                    default: instr = nopClass;
                endcase
            end
            default: instr = nopClass;
        endcase
    end

    // static control fields, looked up on the whole word
    always_comb begin
        fields.aluOp     = aluOpNone;
        fields.aluSource = 1'b0;
        fields.branch    = branchNone;
        case (opcode.raw)
            opAlu: begin
                fields.aluOp     = aluOpReg;
                fields.aluSource = 1'b1;
            end
            opAddi, opMove: fields.aluOp = aluOpAdd;
            opSubi: fields.aluOp = aluOpSub;
            opSlai: fields.aluOp = aluOpSla;
            opSrai: fields.aluOp = aluOpSra;
            opSrli: fields.aluOp = aluOpSrl;
            opBr:   fields.branch = branchAlways;
            opBmi:  fields.branch = branchMinus;
            opBpl:  fields.branch = branchPlus;
            opBz:   fields.branch = branchZero;
            // memory ops, HALT, NOP and unknown words keep zero fields
            default: fields.aluOp = aluOpNone;
        endcase
    end

endmodule

/* hdl/ctrlPkg.sv */
package ctrlPkg;

    // ALU select codes
    localparam logic [2:0] aluOpNone = 3'b000;
    localparam logic [2:0] aluOpReg  = 3'b000; // function comes from the register instr
    localparam logic [2:0] aluOpAdd  = 3'b010;
    localparam logic [2:0] aluOpSub  = 3'b011;
    localparam logic [2:0] aluOpSla  = 3'b100;
    localparam logic [2:0] aluOpSra  = 3'b101;
    localparam logic [2:0] aluOpSrl  = 3'b110;

    // branch condition codes
    localparam logic [2:0] branchNone   = 3'b000;
    localparam logic [2:0] branchAlways = 3'b001;
    localparam logic [2:0] branchMinus  = 3'b011;
    localparam logic [2:0] branchPlus   = 3'b101;
    localparam logic [2:0] branchZero   = 3'b111;

    typedef struct packed {
        logic [2:0] aluOp;
        logic       aluSource; // 1 selects the second register operand
        logic [2:0] branch;
    } ctrlFields;

    typedef struct packed {
        logic writeReg;
        logic memRead;
        logic memWrite;
        logic memRegPC; // register file takes memory data
    } memStrobes;

    // one-cycle pulses from the sequencer to the strobe registers
    typedef struct packed {
        logic latchFields;
        logic regWriteOn;
        logic memReadOn;
        logic memWriteOn;
        logic loadWriteOn;
        logic clearStrobes;
    } stepEvents;

endpackage

/* hdl/isaPkg.sv */
package isaPkg;

    // register ALU operation, the only user of group 00
    localparam logic [5:0] opAlu  = 6'b000000;

    // immediate and memory group
    localparam logic [5:0] opAddi = 6'b000001;
    localparam logic [5:0] opSubi = 6'b000101;
    localparam logic [5:0] opSlai = 6'b001001;
    localparam logic [5:0] opSrai = 6'b001101;
    localparam logic [5:0] opSrli = 6'b010001;
    localparam logic [5:0] opLd   = 6'b010101;
    localparam logic [5:0] opSt   = 6'b011001;
    localparam logic [5:0] opLdsp = 6'b011101;
    localparam logic [5:0] opStsp = 6'b100001;
    localparam logic [5:0] opMove = 6'b100101;

    // branch and system group
    localparam logic [5:0] opBr   = 6'b000010;
    localparam logic [5:0] opBmi  = 6'b000110;
    localparam logic [5:0] opBpl  = 6'b001010;
    localparam logic [5:0] opBz   = 6'b001110;
    localparam logic [5:0] opHalt = 6'b100010;
    localparam logic [5:0] opNop  = 6'b100110;

    localparam logic [1:0] groupAlu = 2'b00;
    localparam logic [1:0] groupImm = 2'b01; // immediates, MOVE, loads, stores
    localparam logic [1:0] groupSys = 2'b10; // branches, HALT, NOP

    // group sits in the low bits, function above it
    typedef struct packed {
        logic [3:0] func;
        logic [1:0] group;
    } opcodeSplit;

    typedef union packed {
        logic [5:0] raw;
        opcodeSplit split;
    } opcodeWord;

    typedef enum logic [2:0] {
        aluClass,
        immClass,
        loadClass,
        storeClass,
        branchClass,
        haltClass,
        nopClass
    } instrClass;

endpackage
